// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= periph_tb
FLIST     ?= periph_top.f
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== logic/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stb_i,
    input  periph_pkg::bus_addr_t adr_i,
    output logic                  timer_stb_o,
    output logic                  prng_stb_o,
    output logic                  leds_stb_o,
    output logic                  ram_stb_o,
    input  periph_pkg::bus_data_t timer_dat_i,
    input  periph_pkg::bus_data_t prng_dat_i,
    input  periph_pkg::bus_data_t leds_dat_i,
    input  periph_pkg::bus_data_t ram_dat_i,
    input  logic                  timer_ack_i,
    input  logic                  prng_ack_i,
    input  logic                  leds_ack_i,
    input  logic                  ram_ack_i,
    output periph_pkg::bus_data_t dat_o,
    output logic                  ack_o
);
    import periph_pkg::*;

    logic       upper_page;
    logic [7:0] page;
    logic       rsv_sel;
    logic       rsv_ack;

    assign upper_page = (adr_i[31:16] == 16'hFFFF);
    assign page       = adr_i[15:8];
    assign rsv_sel    = upper_page && (page <= PAGE_RESERVED_MAX);

    // reserved window answers by itself
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsv_ack <= 1'b0;
        end else begin
            rsv_ack <= stb_i && rsv_sel && !rsv_ack;
        end
    end

    always_comb begin
        timer_stb_o = 1'b0;
        prng_stb_o  = 1'b0;
        leds_stb_o  = 1'b0;
        ram_stb_o   = 1'b0;
        dat_o       = '0;
        ack_o       = 1'b0;
        if (!upper_page) begin
            ram_stb_o = stb_i;
            dat_o     = ram_dat_i;
            ack_o     = ram_ack_i;
        end else begin
            case (page)
                PAGE_TIMER: begin
                    timer_stb_o = stb_i;
                    dat_o       = timer_dat_i;
                    ack_o       = timer_ack_i;
                end
                PAGE_PRNG: begin
                    prng_stb_o = stb_i;
                    dat_o      = prng_dat_i;
                    ack_o      = prng_ack_i;
                end
                PAGE_LEDS: begin
                    leds_stb_o = stb_i;
                    dat_o      = leds_dat_i;
                    ack_o      = leds_ack_i;
                end
                // reserved codes read as zero
                default: ack_o = rsv_ack;
            endcase
        end
    end

endmodule

// ==== logic/leds_wb8.sv ====
`timescale 1ns/1ps

module leds_wb8 (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  periph_pkg::bus_data_t dat_i,
    output periph_pkg::bus_data_t dat_o,
    output logic                  ack_o,
    output periph_pkg::bus_data_t leds_o
);
    import periph_pkg::*;

    bus_data_t leds_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            leds_q <= '0;
            ack_o  <= 1'b0;
        end else begin
            ack_o <= stb_i && !ack_o;
            if (stb_i && !ack_o && we_i) begin
                leds_q <= dat_i;
            end
        end
    end

    assign dat_o  = leds_q;
    assign leds_o = leds_q;

endmodule

// ==== logic/periph_pkg.sv ====
package periph_pkg;

    typedef logic [31:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;
    typedef logic [15:0] timer_count_t;
    typedef logic [31:0] lfsr_state_t;

    // page codes, address bits 15:8 inside the FFFFxxxx page
    localparam logic [7:0] PAGE_TIMER        = 8'hFD;
    localparam logic [7:0] PAGE_PRNG         = 8'hFE;
    localparam logic [7:0] PAGE_LEDS         = 8'hFF;
    localparam logic [7:0] PAGE_RESERVED_MAX = 8'hFC;

    // timer register map
    localparam logic [1:0] TIMER_OFS_RELOAD_LO = 2'd0;
    localparam logic [1:0] TIMER_OFS_RELOAD_HI = 2'd1;
    localparam logic [1:0] TIMER_OFS_CTRL      = 2'd2;
    localparam logic [1:0] TIMER_OFS_STATUS    = 2'd3;

    // control register bits
    localparam int TIMER_CTRL_EN  = 0;
    localparam int TIMER_CTRL_IRQ = 1;

    // galois feedback for the right-shifting generator
    localparam lfsr_state_t PRNG_TAPS = 32'h8020_0003;

endpackage

// ==== logic/periph_top.sv ====
`timescale 1ns/1ps

module periph_top #(
    parameter int RESET_CYCLES   = 16,
    parameter int RAM_ADDR_BITS  = 10,
    parameter int TIMER_PRESCALE = 4
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  button_n_i,
    input  logic                  bus_stb_i,
    input  logic                  bus_we_i,
    input  periph_pkg::bus_addr_t bus_adr_i,
    input  periph_pkg::bus_data_t bus_dat_i,
    output periph_pkg::bus_data_t bus_dat_o,
    output logic                  bus_ack_o,
    output periph_pkg::bus_data_t leds_o,
    output logic                  timer_irq_o
);
    import periph_pkg::*;

    logic         sys_rst_n;
    logic         timer_stb, prng_stb, leds_stb, ram_stb;
    logic         timer_ack, prng_ack, leds_ack, ram_ack;
    bus_data_t    timer_dat, prng_dat, leds_dat, ram_dat;
    timer_count_t timer_reload;
    logic         timer_enable;
    logic         timer_expire;

    reset_stretch #(.RESET_CYCLES(RESET_CYCLES)) u_reset (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .button_n_i  (button_n_i),
        .sys_rst_n_o (sys_rst_n)
    );

    bus_decoder u_decoder (
        .clk         (clk),
        .rst_n_i     (sys_rst_n),
        .stb_i       (bus_stb_i),
        .adr_i       (bus_adr_i),
        .timer_stb_o (timer_stb),
        .prng_stb_o  (prng_stb),
        .leds_stb_o  (leds_stb),
        .ram_stb_o   (ram_stb),
        .timer_dat_i (timer_dat),
        .prng_dat_i  (prng_dat),
        .leds_dat_i  (leds_dat),
        .ram_dat_i   (ram_dat),
        .timer_ack_i (timer_ack),
        .prng_ack_i  (prng_ack),
        .leds_ack_i  (leds_ack),
        .ram_ack_i   (ram_ack),
        .dat_o       (bus_dat_o),
        .ack_o       (bus_ack_o)
    );

    // default region
    ram_wb8 #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_ram (
        .clk     (clk),
        .rst_n_i (sys_rst_n),
        .stb_i   (ram_stb),
        .we_i    (bus_we_i),
        .adr_i   (bus_adr_i[RAM_ADDR_BITS-1:0]),
        .dat_i   (bus_dat_i),
        .dat_o   (ram_dat),
        .ack_o   (ram_ack)
    );

    leds_wb8 u_leds (
        .clk     (clk),
        .rst_n_i (sys_rst_n),
        .stb_i   (leds_stb),
        .we_i    (bus_we_i),
        .dat_i   (bus_dat_i),
        .dat_o   (leds_dat),
        .ack_o   (leds_ack),
        .leds_o  (leds_o)
    );

    timer_regs_wb8 u_timer_regs (
        .clk      (clk),
        .rst_n_i  (sys_rst_n),
        .stb_i    (timer_stb),
        .we_i     (bus_we_i),
        .adr_i    (bus_adr_i[1:0]),
        .dat_i    (bus_dat_i),
        .dat_o    (timer_dat),
        .ack_o    (timer_ack),
        .expire_i (timer_expire),
        .reload_o (timer_reload),
        .enable_o (timer_enable),
        .irq_o    (timer_irq_o)
    );

    timer_counter #(.TIMER_PRESCALE(TIMER_PRESCALE)) u_timer_cnt (
        .clk      (clk),
        .rst_n_i  (sys_rst_n),
        .enable_i (timer_enable),
        .reload_i (timer_reload),
        .expire_o (timer_expire)
    );

    prng_wb8 u_prng (
        .clk     (clk),
        .rst_n_i (sys_rst_n),
        .stb_i   (prng_stb),
        .we_i    (bus_we_i),
        .adr_i   (bus_adr_i[1:0]),
        .dat_i   (bus_dat_i),
        .dat_o   (prng_dat),
        .ack_o   (prng_ack)
    );

endmodule

// ==== logic/prng_wb8.sv ====
`timescale 1ns/1ps

module prng_wb8 (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  logic [1:0]            adr_i,
    input  periph_pkg::bus_data_t dat_i,
    output periph_pkg::bus_data_t dat_o,
    output logic                  ack_o
);
    import periph_pkg::*;

    lfsr_state_t state;
    lfsr_state_t state_next;
    logic        access;

    assign access = stb_i && !ack_o;

    // one galois step, shifting right
    assign state_next = (state >> 1) ^ (state[0] ? PRNG_TAPS : '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= lfsr_state_t'(1);
            ack_o <= 1'b0;
            dat_o <= '0;
        end else begin
            ack_o <= access;
            if (access) begin
                if (we_i) begin
                    state[{adr_i, 3'b000} +: 8] <= dat_i;
                end else begin
                    dat_o <= state[{adr_i, 3'b000} +: 8];
                    // only the low byte read moves it on
                    if (adr_i == 2'd0) begin
                        state <= state_next;
                    end
                end
            end
        end
    end

endmodule

// ==== logic/ram_wb8.sv ====
`timescale 1ns/1ps

module ram_wb8 #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     stb_i,
    input  logic                     we_i,
    input  logic [RAM_ADDR_BITS-1:0] adr_i,
    input  periph_pkg::bus_data_t    dat_i,
    output periph_pkg::bus_data_t    dat_o,
    output logic                     ack_o
);
    import periph_pkg::*;

    bus_data_t mem [2**RAM_ADDR_BITS];
    logic      access;

    assign access = stb_i && !ack_o;

    always_ff @(posedge clk) begin
        if (access && we_i) begin
            mem[adr_i] <= dat_i;
        end
        if (access) begin
            dat_o <= mem[adr_i];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

endmodule

// ==== logic/reset_stretch.sv ====
`timescale 1ns/1ps

module reset_stretch #(
    parameter int RESET_CYCLES = 16
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic button_n_i,
    output logic sys_rst_n_o
);
    localparam int CNT_W = $clog2(RESET_CYCLES + 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt         <= '0;
            sys_rst_n_o <= 1'b0;
        end else if (!button_n_i) begin
            // button restarts the hold period
            cnt         <= '0;
            sys_rst_n_o <= 1'b0;
        end else begin
            if (cnt != CNT_W'(RESET_CYCLES)) begin
                cnt <= cnt + 1'b1;
            end
            sys_rst_n_o <= (cnt == CNT_W'(RESET_CYCLES));
        end
    end

endmodule

// ==== logic/timer_counter.sv ====
`timescale 1ns/1ps

module timer_counter #(
    parameter int TIMER_PRESCALE = 4
) (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     enable_i,
    input  periph_pkg::timer_count_t reload_i,
    output logic                     expire_o
);
    import periph_pkg::*;

    localparam int PW = (TIMER_PRESCALE > 1) ? $clog2(TIMER_PRESCALE) : 1;

    logic [PW-1:0] presc;
    timer_count_t  count;
    logic          tick;

    assign tick = (presc == PW'(TIMER_PRESCALE - 1));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            presc    <= '0;
            count    <= '0;
            expire_o <= 1'b0;
        end else if (!enable_i) begin
            // parked at the reload value
            presc    <= '0;
            count    <= reload_i;
            expire_o <= 1'b0;
        end else begin
            expire_o <= 1'b0;
            presc    <= tick ? '0 : presc + 1'b1;
            if (tick) begin
                if (count == '0) begin
                    expire_o <= 1'b1;
                    count    <= reload_i;
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/timer_regs_wb8.sv ====
`timescale 1ns/1ps

module timer_regs_wb8 (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     stb_i,
    input  logic                     we_i,
    input  logic [1:0]               adr_i,
    input  periph_pkg::bus_data_t    dat_i,
    output periph_pkg::bus_data_t    dat_o,
    output logic                     ack_o,
    input  logic                     expire_i,
    output periph_pkg::timer_count_t reload_o,
    output logic                     enable_o,
    output logic                     irq_o
);
    import periph_pkg::*;

    bus_data_t  reload_lo;
    bus_data_t  reload_hi;
    logic [1:0] ctrl;
    logic       status;
    logic       access;
    bus_data_t  rd_data;

    assign access = stb_i && !ack_o;

    always_comb begin
        case (adr_i)
            TIMER_OFS_RELOAD_LO: rd_data = reload_lo;
            TIMER_OFS_RELOAD_HI: rd_data = reload_hi;
            TIMER_OFS_CTRL:      rd_data = {6'd0, ctrl};
            default:             rd_data = {7'd0, status};
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reload_lo <= '0;
            reload_hi <= '0;
            ctrl      <= '0;
            status    <= 1'b0;
            ack_o     <= 1'b0;
            dat_o     <= '0;
        end else begin
            ack_o <= access;
            if (access) begin
                dat_o <= rd_data;
            end
            if (access && we_i) begin
                case (adr_i)
                    TIMER_OFS_RELOAD_LO: reload_lo <= dat_i;
                    TIMER_OFS_RELOAD_HI: reload_hi <= dat_i;
                    TIMER_OFS_CTRL:      ctrl      <= dat_i[1:0];
                    default:             if (dat_i[0]) status <= 1'b0;
                endcase
            end
            // a new expiry beats a clear in the same cycle
            if (expire_i) begin
                status <= 1'b1;
            end
        end
    end

    assign reload_o = {reload_hi, reload_lo};
    assign enable_o = ctrl[TIMER_CTRL_EN];
    assign irq_o    = status && ctrl[TIMER_CTRL_IRQ];

endmodule

// ==== periph_top.f ====
logic/periph_pkg.sv
logic/reset_stretch.sv
logic/bus_decoder.sv
logic/ram_wb8.sv
logic/leds_wb8.sv
logic/timer_regs_wb8.sv
logic/timer_counter.sv
logic/prng_wb8.sv
logic/periph_top.sv
sim/periph_properties.sv
sim/periph_tb.sv

// ==== sim/periph_properties.sv ====
`timescale 1ns/1ps

module periph_properties (
    input logic clk,
    input logic rst_n_i,
    input logic sys_rst_n_i,
    input logic bus_stb_i,
    input logic bus_ack_i,
    input logic timer_irq_i
);

    int unsigned failures = 0;

    ack_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n_i) bus_ack_i |=> !bus_ack_i
    ) else begin
        failures = failures + 1;
        $error("bus_ack_o high for two cycles in a row");
    end

    // ack only answers a strobe seen one cycle earlier
    ack_after_strobe: assert property (
        @(posedge clk) disable iff (!rst_n_i) bus_ack_i |-> $past(bus_stb_i)
    ) else begin
        failures = failures + 1;
        $error("bus_ack_o high without a strobe in the cycle before");
    end

    irq_quiet_in_reset: assert property (
        @(posedge clk) disable iff (!rst_n_i) !sys_rst_n_i |-> !timer_irq_i
    ) else begin
        failures = failures + 1;
        $error("timer_irq_o high while the internal reset is active");
    end

endmodule

bind periph_top periph_properties u_properties (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .sys_rst_n_i (sys_rst_n),
    .bus_stb_i   (bus_stb_i),
    .bus_ack_i   (bus_ack_o),
    .timer_irq_i (timer_irq_o)
);

// ==== sim/periph_tb.sv ====
`timescale 1ns/1ps

module periph_tb;
    import periph_pkg::*;

    localparam int RESET_CYCLES   = 16;
    localparam int RAM_ADDR_BITS  = 10;
    localparam int TIMER_PRESCALE = 4;
    localparam int HALF_PERIOD    = 4;
    localparam int DRIVE_DELAY    = 1;
    localparam int ACK_LIMIT      = 8;
    localparam int RAM_WRITES     = 32;
    localparam int TIMER_RELOAD   = 5;
    localparam int TIMER_WAIT     = 2 * (TIMER_RELOAD + 1) * TIMER_PRESCALE;
    // about 130 accesses of at most 4 cycles, plus the reset and timer waits
    localparam int RUN_CYCLES     = 2 * (RESET_CYCLES + 4) + 2 * TIMER_WAIT + 4 * 130 + 200;

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic        button_n_i;
    logic        bus_stb_i;
    logic        bus_we_i;
    bus_addr_t   bus_adr_i;
    bus_data_t   bus_dat_i;
    bus_data_t   bus_dat_o;
    logic        bus_ack_o;
    bus_data_t   leds_o;
    logic        timer_irq_o;
    logic [31:0] lcg_state;
    bus_data_t   ram_model [2**RAM_ADDR_BITS];

    periph_top #(
        .RESET_CYCLES   (RESET_CYCLES),
        .RAM_ADDR_BITS  (RAM_ADDR_BITS),
        .TIMER_PRESCALE (TIMER_PRESCALE)
    ) dut (.*);

    always #HALF_PERIOD clk = ~clk;

    task automatic stop_on_failure();
        $display("TEST FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic expect_equal(input string name, input bus_data_t expected,
                                input bus_data_t actual);
        assert (actual === expected) else begin
            $display("MISMATCH at %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // swap halves, the high bits of an LCG are the better ones
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    function automatic lfsr_state_t lfsr_step(input lfsr_state_t s);
        lfsr_state_t next_s;
        next_s = {1'b0, s[31:1]};
        if (s[0])
            next_s = next_s ^ PRNG_TAPS;
        return next_s;
    endfunction

    function automatic bus_addr_t page_addr(input logic [7:0] page, input logic [1:0] ofs);
        return {16'hFFFF, page, 6'd0, ofs};
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // called and returns 1 ns after a rising edge
    task automatic bus_access(input bus_addr_t adr, input logic we, input bus_data_t wdat,
                              output bus_data_t rdat);
        int edges;
        bus_adr_i = adr;
        bus_we_i  = we;
        bus_dat_i = wdat;
        bus_stb_i = 1'b1;
        edges     = 0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            edges++;
        end while (!bus_ack_o && edges < ACK_LIMIT);
        assert (bus_ack_o) else begin
            $display("no acknowledge within %0d cycles for address %h", ACK_LIMIT, adr);
            stop_on_failure();
        end
        assert (edges == 1) else begin
            $display("MISMATCH at %0t: bus_ack_o latency expected 1, actual %0d", $time, edges);
            stop_on_failure();
        end
        rdat      = bus_dat_o;
        bus_stb_i = 1'b0;
        bus_we_i  = 1'b0;
        idle_cycles(1);
    endtask

    task automatic bus_write(input bus_addr_t adr, input bus_data_t dat);
        bus_data_t discard;
        bus_access(adr, 1'b1, dat, discard);
    endtask

    task automatic bus_read(input bus_addr_t adr, output bus_data_t dat);
        bus_access(adr, 1'b0, 8'h00, dat);
    endtask

    task automatic ram_random_access();
        bus_addr_t addrs [RAM_WRITES];
        bus_addr_t alias_addr;
        bus_data_t wdat;
        bus_data_t rdat;
        for (int i = 0; i < RAM_WRITES; i++) begin
            addrs[i] = next_random();
            if (addrs[i][31:16] == 16'hFFFF)
                addrs[i][31] = 1'b0;
            wdat = bus_data_t'(next_random());
            bus_write(addrs[i], wdat);
            ram_model[addrs[i][RAM_ADDR_BITS-1:0]] = wdat;
        end
        // same cell through other upper address bits
        alias_addr = addrs[3] ^ (32'd1 << RAM_ADDR_BITS);
        wdat = ~ram_model[alias_addr[RAM_ADDR_BITS-1:0]];
        bus_write(alias_addr, wdat);
        ram_model[alias_addr[RAM_ADDR_BITS-1:0]] = wdat;
        for (int i = 0; i < RAM_WRITES; i++) begin
            bus_read(addrs[i], rdat);
            expect_equal("bus_dat_o (ram)", ram_model[addrs[i][RAM_ADDR_BITS-1:0]], rdat);
        end
    endtask

    task automatic leds_and_reserved();
        bus_data_t led_val;
        bus_data_t rdat;
        bus_addr_t rsv_addr;
        bus_addr_t ram_addr;
        logic [7:0] code;
        led_val = bus_data_t'(next_random()) | 8'h01;
        bus_write(page_addr(PAGE_LEDS, 2'd0), led_val);
        expect_equal("leds_o", led_val, leds_o);
        bus_read(page_addr(PAGE_LEDS, 2'd0), rdat);
        expect_equal("bus_dat_o (leds)", led_val, rdat);
        code = bus_data_t'(next_random());
        if (code > PAGE_RESERVED_MAX)
            code = code - 8'd16;
        rsv_addr = {16'hFFFF, code, bus_data_t'(next_random())};
        bus_read(rsv_addr, rdat);
        expect_equal("bus_dat_o (reserved)", 8'h00, rdat);
        // the RAM cell a leaking reserved write would land in
        ram_addr = {16'h0001, rsv_addr[15:0]};
        bus_write(ram_addr, ~led_val);
        ram_model[ram_addr[RAM_ADDR_BITS-1:0]] = ~led_val;
        bus_write(rsv_addr, ~led_val ^ 8'h3C);
        expect_equal("leds_o", led_val, leds_o);
        bus_read(ram_addr, rdat);
        expect_equal("bus_dat_o (ram)", ~led_val, rdat);
        bus_read(page_addr(PAGE_LEDS, 2'd0), rdat);
        expect_equal("bus_dat_o (leds)", led_val, rdat);
    endtask

    task automatic timer_expiry();
        bus_data_t rdat;
        bus_write(page_addr(PAGE_TIMER, TIMER_OFS_RELOAD_LO), 8'(TIMER_RELOAD));
        bus_write(page_addr(PAGE_TIMER, TIMER_OFS_RELOAD_HI), 8'h00);
        bus_write(page_addr(PAGE_TIMER, TIMER_OFS_CTRL), 8'h03);
        bus_read(page_addr(PAGE_TIMER, TIMER_OFS_STATUS), rdat);
        expect_equal("timer status", 8'h00, rdat);
        idle_cycles(TIMER_WAIT);
        bus_read(page_addr(PAGE_TIMER, TIMER_OFS_STATUS), rdat);
        expect_equal("timer status", 8'h01, rdat);
        expect_equal("timer_irq_o", 8'h01, bus_data_t'(timer_irq_o));
        // stop counting so no new expiry lands on the clear
        bus_write(page_addr(PAGE_TIMER, TIMER_OFS_CTRL), 8'h02);
        bus_write(page_addr(PAGE_TIMER, TIMER_OFS_STATUS), 8'h01);
        bus_read(page_addr(PAGE_TIMER, TIMER_OFS_STATUS), rdat);
        expect_equal("timer status", 8'h00, rdat);
        expect_equal("timer_irq_o", 8'h00, bus_data_t'(timer_irq_o));
        // flag without the interrupt enable
        bus_write(page_addr(PAGE_TIMER, TIMER_OFS_CTRL), 8'h01);
        idle_cycles(TIMER_WAIT);
        bus_read(page_addr(PAGE_TIMER, TIMER_OFS_STATUS), rdat);
        expect_equal("timer status", 8'h01, rdat);
        expect_equal("timer_irq_o", 8'h00, bus_data_t'(timer_irq_o));
        // counter off, the pending flag raises the interrupt again
        bus_write(page_addr(PAGE_TIMER, TIMER_OFS_CTRL), 8'h02);
    endtask

    task automatic generator_sequence();
        lfsr_state_t model;
        bus_data_t   rdat;
        model = next_random();
        for (int k = 0; k < 4; k++)
            bus_write(page_addr(PAGE_PRNG, 2'(k)), model[8*k +: 8]);
        for (int i = 0; i < 8; i++) begin
            bus_read(page_addr(PAGE_PRNG, 2'd0), rdat);
            expect_equal("bus_dat_o (prng)", model[7:0], rdat);
            model = lfsr_step(model);
        end
        for (int k = 1; k < 4; k++) begin
            bus_read(page_addr(PAGE_PRNG, 2'(k)), rdat);
            expect_equal("bus_dat_o (prng)", model[8*k +: 8], rdat);
        end
        bus_read(page_addr(PAGE_PRNG, 2'd0), rdat);
        expect_equal("bus_dat_o (prng)", model[7:0], rdat);
    endtask

    task automatic button_reset();
        bus_data_t rdat;
        // interrupt still pending from the timer test
        expect_equal("timer_irq_o", 8'h01, bus_data_t'(timer_irq_o));
        bus_write(page_addr(PAGE_LEDS, 2'd0), 8'h5A);
        expect_equal("leds_o", 8'h5A, leds_o);
        button_n_i = 1'b0;
        idle_cycles(1);
        button_n_i = 1'b1;
        idle_cycles(RESET_CYCLES + 4);
        expect_equal("leds_o", 8'h00, leds_o);
        expect_equal("timer_irq_o", 8'h00, bus_data_t'(timer_irq_o));
        bus_read(page_addr(PAGE_LEDS, 2'd0), rdat);
        expect_equal("bus_dat_o (leds)", 8'h00, rdat);
        bus_read(page_addr(PAGE_PRNG, 2'd0), rdat);
        expect_equal("bus_dat_o (prng)", 8'h01, rdat);
    endtask

    initial begin
        repeat (RUN_CYCLES) @(posedge clk);
        $display("watchdog expired, tests still running after %0d cycles", RUN_CYCLES);
        stop_on_failure();
    end

    initial begin
        wait (dut.u_properties.failures != 0);
        $display("a bound property on the bus or the interrupt failed");
        stop_on_failure();
    end

    initial begin
        lcg_state  = 32'd87531;
        rst_n_i    = 1'b0;
        button_n_i = 1'b1;
        bus_stb_i  = 1'b0;
        bus_we_i   = 1'b0;
        bus_adr_i  = '0;
        bus_dat_i  = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst_n_i = 1'b1;
        idle_cycles(RESET_CYCLES + 4);
        ram_random_access();
        leds_and_reserved();
        timer_expiry();
        generator_sequence();
        button_reset();
        if (dut.u_properties.failures == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_on_failure();
        end
    end

endmodule
